//--- rtl/tbw_pkg.sv
package tbw_pkg;

  // ======================================================================
  // row layout and sequence length
  // ======================================================================

  localparam int lanes   = 4;  // data lanes in one CB or TB row
  localparam int seq_max = 5;  // steps in the nonlinear fill

  // ======================================================================
  // mapper select fields
  // ======================================================================

  typedef enum logic {
    cb_src = 1'b0,  // row comes from the covariance buffer
    nl_src = 1'b1   // row comes from the nonlinear terms
  } tb_src_e;

  typedef enum logic [1:0] {
    dir_idle = 2'b00,
    dir_pos  = 2'b01,
    dir_neg  = 2'b10,
    dir_new  = 2'b11
  } tb_dir_e;

  typedef struct packed {
    tb_src_e src;
    tb_dir_e dir;
  } tb_sel_t;

  // ======================================================================
  // command opcodes
  // ======================================================================

  typedef enum logic [2:0] {
    op_nop      = 3'd0,
    op_copy_pos = 3'd1,
    op_copy_neg = 3'd2,
    op_copy_new = 3'd3,
    op_nl_fill  = 3'd4
  } tb_op_e;

endpackage

//--- rtl/cov_bank.sv
module cov_bank
  import tbw_pkg::*;
#(
  parameter int rsa_dw = 32,
  parameter int cb_aw  = 6
) (
  input  logic                                clk,
  input  logic                                sys_rst,
  input  logic                                we,
  input  logic        [cb_aw-1:0]             waddr,
  input  logic signed [lanes-1:0][rsa_dw-1:0] wdata,
  input  logic                                re,
  input  logic        [cb_aw-1:0]             raddr,
  output logic signed [lanes-1:0][rsa_dw-1:0] rdata
);

  logic signed [lanes-1:0][rsa_dw-1:0] mem [2**cb_aw];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // the read port holds its last row while re is low
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

//--- rtl/seq_counter.sv
module seq_counter
  import tbw_pkg::*;
#(
  parameter int seq_dw = 3
) (
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              start,
  output logic [seq_dw-1:0] seq_cnt
);

  // step numbers run 1 to seq_max and 0 means the sequence is idle
  localparam logic [seq_dw-1:0] last_step = seq_dw'(seq_max);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      seq_cnt <= '0;
    end else if (start) begin
      seq_cnt <= seq_dw'(1);
    end else if (seq_cnt == last_step) begin
      seq_cnt <= '0;  // back to idle until the next start
    end else if (seq_cnt != '0) begin
      seq_cnt <= seq_cnt + seq_dw'(1);
    end
  end

endmodule

//--- rtl/tb_dina_map.sv
module tb_dina_map
  import tbw_pkg::*;
#(
  parameter int rsa_dw = 32,
  parameter int seq_dw = 3
) (
  input  logic                                clk,
  input  logic                                sys_rst,
  input  tb_sel_t                             sel,
  input  logic                                lk0,
  input  logic        [seq_dw-1:0]            seq_cnt,
  input  logic signed [lanes-1:0][rsa_dw-1:0] cb_row,
  input  logic signed [rsa_dw-1:0]            fxi_13,
  input  logic signed [rsa_dw-1:0]            fxi_23,
  output logic signed [lanes-1:0][rsa_dw-1:0] dina
);

  localparam logic signed [rsa_dw-1:0] one = rsa_dw'(1);

  logic signed [lanes-1:0][rsa_dw-1:0] cb_map;
  logic signed [lanes-1:0][rsa_dw-1:0] nl_map;

  // ======================================================================
  // covariance buffer placement
  // ======================================================================

  always_comb begin
    cb_map = '0;
    case (sel.dir)
      dir_pos: begin
        cb_map = cb_row;
      end
      dir_neg: begin
        for (int i = 0; i < lanes; i++) begin
          cb_map[i] = cb_row[lanes-1-i];
        end
      end
      dir_new: begin
        if (lk0) begin  // new landmark goes into the low half
          cb_map[0] = cb_row[0];
          cb_map[1] = cb_row[1];
        end else begin
          cb_map[2] = cb_row[0];
          cb_map[3] = cb_row[1];
        end
      end
      default: begin
        cb_map = '0;
      end
    endcase
  end

  // ======================================================================
  // motion Jacobian rows
  // ======================================================================

  // seq_cnt is used as it arrives so each step lands one cycle later
  always_comb begin
    nl_map = '0;
    case (seq_cnt)
      seq_dw'(1): begin
        nl_map[0] = fxi_13;
      end
      seq_dw'(2): begin
        nl_map[0] = one;
        nl_map[1] = fxi_23;
      end
      seq_dw'(3): begin
        nl_map[2] = one;
      end
      seq_dw'(4): begin
        nl_map[1] = one;
        nl_map[2] = fxi_13;
      end
      seq_dw'(5): begin
        nl_map[2] = fxi_23;
      end
      default: begin
        nl_map = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      dina <= '0;
    end else if (sel.src == nl_src) begin
      dina <= nl_map;
    end else begin
      dina <= cb_map;
    end
  end

endmodule

//--- rtl/temp_bank.sv
module temp_bank
  import tbw_pkg::*;
#(
  parameter int rsa_dw = 32,
  parameter int tb_aw  = 6
) (
  input  logic                                clk,
  input  logic                                sys_rst,
  input  logic                                we,
  input  logic        [tb_aw-1:0]             waddr,
  input  logic signed [lanes-1:0][rsa_dw-1:0] wdata,
  input  logic                                re,
  input  logic        [tb_aw-1:0]             raddr,
  output logic signed [lanes-1:0][rsa_dw-1:0] rdata
);

  logic signed [lanes-1:0][rsa_dw-1:0] mem [2**tb_aw];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;  // written rows come straight from the mapper
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

//--- rtl/tb_write_ctrl.sv
module tb_write_ctrl
  import tbw_pkg::*;
#(
  parameter int cb_aw  = 6,
  parameter int tb_aw  = 6,
  parameter int seq_dw = 3
) (
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              cmd_valid,
  input  tb_op_e            cmd_op,
  input  logic [cb_aw-1:0]  cmd_cb_addr,
  input  logic [tb_aw-1:0]  cmd_tb_addr,
  input  logic              lk0,
  input  logic [seq_dw-1:0] seq_cnt,
  output logic              cb_re,
  output logic [cb_aw-1:0]  cb_raddr,
  output logic              seq_start,
  output tb_sel_t           sel,
  output logic              map_lk0,
  output logic              tb_we,
  output logic [tb_aw-1:0]  tb_waddr,
  output logic              busy
);

  // first pipeline stage lines up with the cycle the mapper samples its inputs
  typedef struct packed {
    logic             we;
    tb_sel_t          sel;
    logic             lk0;
    logic [tb_aw-1:0] addr;
  } stage_t;

  localparam logic [seq_dw-1:0] last_step = seq_dw'(seq_max);

  stage_t           s1;
  logic             s2_we;
  logic [tb_aw-1:0] s2_addr;
  logic             fill_tail;  // the cycle after the last step is still busy
  logic             accept;
  logic             is_copy;
  logic             copy_acc;
  logic             fill_next;
  tb_dir_e          copy_dir;

  // ======================================================================
  // command decode
  // ======================================================================

  always_comb begin
    is_copy  = 1'b1;
    copy_dir = dir_idle;
    case (cmd_op)
      op_copy_pos: copy_dir = dir_pos;
      op_copy_neg: copy_dir = dir_neg;
      op_copy_new: copy_dir = dir_new;
      default:     is_copy  = 1'b0;
    endcase
  end

  assign busy      = (seq_cnt != '0) | fill_tail;
  assign accept    = cmd_valid & ~busy;  // strobes during a fill are lost
  assign copy_acc  = accept & is_copy;
  assign seq_start = accept & (cmd_op == op_nl_fill);
  assign fill_next = (seq_cnt != '0) & (seq_cnt != last_step);

  assign cb_re    = copy_acc;
  assign cb_raddr = cmd_cb_addr;

  // ======================================================================
  // select and write pipeline
  // ======================================================================

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      s1        <= '0;
      s2_we     <= 1'b0;
      s2_addr   <= '0;
      fill_tail <= 1'b0;
    end else begin
      if (copy_acc) begin
        s1 <= '{we: 1'b1, sel: '{src: cb_src, dir: copy_dir}, lk0: lk0, addr: cmd_tb_addr};
      end else if (seq_start) begin
        s1 <= '{we: 1'b1, sel: '{src: nl_src, dir: dir_idle}, lk0: 1'b0, addr: cmd_tb_addr};
      end else if (fill_next) begin
        // one row per step at consecutive addresses
        s1 <= '{we: 1'b1, sel: '{src: nl_src, dir: dir_idle}, lk0: 1'b0,
                addr: s1.addr + tb_aw'(1)};
      end else begin
        s1 <= '{we: 1'b0, sel: '{src: cb_src, dir: dir_idle}, lk0: 1'b0, addr: s1.addr};
      end
      s2_we     <= s1.we;
      s2_addr   <= s1.addr;
      fill_tail <= (seq_cnt == last_step);
    end
  end

  assign sel      = s1.sel;
  assign map_lk0  = s1.lk0;
  assign tb_we    = s2_we;  // same cycle as the registered mapper row
  assign tb_waddr = s2_addr;

endmodule

//--- rtl/tb_write_top.sv
module tb_write_top
  import tbw_pkg::*;
#(
  parameter int rsa_dw = 32,
  parameter int cb_aw  = 6,
  parameter int tb_aw  = 6,
  parameter int seq_dw = 3
) (
  input  logic                                clk,
  input  logic                                sys_rst,
  input  logic                                cb_we,
  input  logic        [cb_aw-1:0]             cb_waddr,
  input  logic signed [lanes-1:0][rsa_dw-1:0] cb_wdata,
  input  logic                                cmd_valid,
  input  tb_op_e                              cmd_op,
  input  logic        [cb_aw-1:0]             cmd_cb_addr,
  input  logic        [tb_aw-1:0]             cmd_tb_addr,
  input  logic                                lk0,
  input  logic signed [rsa_dw-1:0]            fxi_13,
  input  logic signed [rsa_dw-1:0]            fxi_23,
  input  logic                                tb_re,
  input  logic        [tb_aw-1:0]             tb_raddr,
  output logic signed [lanes-1:0][rsa_dw-1:0] tb_rdata,
  output logic                                busy
);

  logic                                cb_re;
  logic        [cb_aw-1:0]             cb_raddr;
  logic signed [lanes-1:0][rsa_dw-1:0] cb_rdata;
  logic                                seq_start;
  logic        [seq_dw-1:0]            seq_cnt;
  tb_sel_t                             sel;
  logic                                map_lk0;
  logic                                tb_we;
  logic        [tb_aw-1:0]             tb_waddr;
  logic signed [lanes-1:0][rsa_dw-1:0] dina;

  // ======================================================================
  // covariance buffer feeds the mapper, the mapper feeds the TB
  // ======================================================================

  cov_bank #(.rsa_dw(rsa_dw), .cb_aw(cb_aw)) u_cov_bank (
    .clk(clk), .sys_rst(sys_rst), .we(cb_we), .waddr(cb_waddr), .wdata(cb_wdata),
    .re(cb_re), .raddr(cb_raddr), .rdata(cb_rdata)
  );

  tb_write_ctrl #(.cb_aw(cb_aw), .tb_aw(tb_aw), .seq_dw(seq_dw)) u_ctrl (
    .clk(clk), .sys_rst(sys_rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .cmd_cb_addr(cmd_cb_addr), .cmd_tb_addr(cmd_tb_addr), .lk0(lk0), .seq_cnt(seq_cnt),
    .cb_re(cb_re), .cb_raddr(cb_raddr), .seq_start(seq_start), .sel(sel),
    .map_lk0(map_lk0), .tb_we(tb_we), .tb_waddr(tb_waddr), .busy(busy)
  );

  seq_counter #(.seq_dw(seq_dw)) u_seq (
    .clk(clk), .sys_rst(sys_rst), .start(seq_start), .seq_cnt(seq_cnt)
  );

  tb_dina_map #(.rsa_dw(rsa_dw), .seq_dw(seq_dw)) u_map (
    .clk(clk), .sys_rst(sys_rst), .sel(sel), .lk0(map_lk0), .seq_cnt(seq_cnt),
    .cb_row(cb_rdata), .fxi_13(fxi_13), .fxi_23(fxi_23), .dina(dina)
  );

  temp_bank #(.rsa_dw(rsa_dw), .tb_aw(tb_aw)) u_temp_bank (
    .clk(clk), .sys_rst(sys_rst), .we(tb_we), .waddr(tb_waddr), .wdata(dina),
    .re(tb_re), .raddr(tb_raddr), .rdata(tb_rdata)
  );

endmodule

//--- sim/tb_write_chk.sv
module tb_write_chk
  import tbw_pkg::*;
(
  input logic   clk,
  input logic   sys_rst,
  input logic   cmd_valid,
  input tb_op_e cmd_op,
  input logic   busy,
  input logic   tb_we
);

  logic copy_strobe;
  logic fill_strobe;
  logic cmd_seen;  // set by the first strobe after reset

  assign copy_strobe = cmd_valid & ~busy & (cmd_op inside {op_copy_pos, op_copy_neg, op_copy_new});
  assign fill_strobe = cmd_valid & ~busy & (cmd_op == op_nl_fill);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cmd_seen <= 1'b0;
    end else if (cmd_valid) begin
      cmd_seen <= 1'b1;
    end
  end

  // ======================================================================
  // write timing and busy window
  // ======================================================================

  copy_lands: assert property (@(posedge clk) disable iff (sys_rst)
    copy_strobe |-> ##2 tb_we)
    else $error("tb_we missing two cycles after an accepted copy strobe");

  // busy covers the five steps and the cycle of the last write
  fill_window: assert property (@(posedge clk) disable iff (sys_rst)
    fill_strobe |=> busy ##1 busy ##1 busy ##1 busy ##1 busy ##1 busy ##1 !busy)
    else $error("busy did not last exactly six cycles after a fill strobe");

  quiet_start: assert property (@(posedge clk) disable iff (sys_rst)
    !cmd_seen |-> !tb_we)
    else $error("tb_we rose before any command arrived");

endmodule

//--- sim/tb_write_mon.sv
module tb_write_mon
  import tbw_pkg::*;
#(
  parameter int rsa_dw = 32,
  parameter int cb_aw  = 6,
  parameter int tb_aw  = 6
) (
  input  logic                                clk,
  input  logic                                sys_rst,
  input  logic                                cb_we,
  input  logic        [cb_aw-1:0]             cb_waddr,
  input  logic signed [lanes-1:0][rsa_dw-1:0] cb_wdata,
  input  logic                                cmd_valid,
  input  tb_op_e                              cmd_op,
  input  logic        [cb_aw-1:0]             cmd_cb_addr,
  input  logic        [tb_aw-1:0]             cmd_tb_addr,
  input  logic                                lk0,
  input  logic signed [rsa_dw-1:0]            fxi_13,
  input  logic signed [rsa_dw-1:0]            fxi_23,
  input  logic                                tb_re,
  input  logic        [tb_aw-1:0]             tb_raddr,
  input  logic signed [lanes-1:0][rsa_dw-1:0] tb_rdata,
  input  int                                  phase,
  input  logic                                report,
  output int                                  chk_cnt,
  output int                                  err_cnt
);

  typedef logic signed [lanes-1:0][rsa_dw-1:0] row_t;

  row_t             cb_model [2**cb_aw];
  row_t             tb_model [2**tb_aw];
  int               busy_left;  // cycles of busy still owed by the last fill
  logic             rd_pend;
  logic [tb_aw-1:0] rd_addr;
  row_t             rd_exp;

  function automatic string phase_name(int p);
    case (p)
      1:       return "cb_load";
      2:       return "straight_copy";
      3:       return "reversal";
      4:       return "new_landmark";
      5:       return "nonlinear_fill";
      6:       return "pipelining";
      default: return "reset";
    endcase
  endfunction

  // ======================================================================
  // reference mapping gives one TB row per copy or fill step
  // ======================================================================

  function automatic row_t expected_row(tb_op_e op, logic lk, int step, row_t cb_row,
                                        logic signed [rsa_dw-1:0] f13,
                                        logic signed [rsa_dw-1:0] f23);
    row_t r;
    r = '0;
    case (op)
      op_copy_pos: r = cb_row;
      op_copy_neg: begin
        for (int i = 0; i < lanes; i++) begin
          r[i] = cb_row[lanes-1-i];
        end
      end
      op_copy_new: begin
        if (lk) begin  // landmark in the low half
          r[0] = cb_row[0];
          r[1] = cb_row[1];
        end else begin
          r[2] = cb_row[0];
          r[3] = cb_row[1];
        end
      end
      op_nl_fill: begin
        case (step)
          1: r[0] = f13;
          2: begin
            r[0] = rsa_dw'(1);
            r[1] = f23;
          end
          3: r[2] = rsa_dw'(1);
          4: begin
            r[1] = rsa_dw'(1);
            r[2] = f13;
          end
          5: r[2] = f23;
          default: r = '0;
        endcase
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  always @(posedge clk) begin : model_update
    logic [tb_aw-1:0] wa;
    if (sys_rst) begin
      busy_left <= 0;
      rd_pend   <= 1'b0;
    end else begin
      if (cb_we) begin
        cb_model[cb_waddr] <= cb_wdata;
      end
      if (cmd_valid && busy_left == 0 && cmd_op == op_nl_fill) begin
        busy_left <= seq_max + 1;  // five steps and the last write cycle
        for (int s = 1; s <= seq_max; s++) begin
          wa = cmd_tb_addr + tb_aw'(s - 1);
          tb_model[wa] <= expected_row(op_nl_fill, 1'b0, s, '0, fxi_13, fxi_23);
        end
      end else begin
        if (cmd_valid && busy_left == 0 && cmd_op != op_nop) begin
          tb_model[cmd_tb_addr] <= expected_row(cmd_op, lk0, 0, cb_model[cmd_cb_addr],
                                                fxi_13, fxi_23);
        end
        if (busy_left != 0) begin
          busy_left <= busy_left - 1;  // strobes in this window are dropped
        end
      end
      rd_pend <= tb_re;
      rd_addr <= tb_raddr;
      rd_exp  <= tb_model[tb_raddr];
    end
  end

  // read data is registered so it is compared half a cycle after it updates
  always @(negedge clk) begin
    if (sys_rst) begin
      chk_cnt = 0;
      err_cnt = 0;
    end else if (rd_pend) begin
      chk_cnt++;
      if (tb_rdata !== rd_exp) begin
        err_cnt++;
        $display("[FAIL] %s row %0d expected %h actual %h",
                 phase_name(phase), rd_addr, rd_exp, tb_rdata);
      end
    end
  end

  always @(posedge report) begin
    $display("closing count: %0d rows checked, %0d errors", chk_cnt, err_cnt);
  end

endmodule

//--- sim/tb_write_tb.sv
module tb_write_tb
  import tbw_pkg::*;
();

  localparam int rsa_dw = 32;
  localparam int cb_aw  = 6;
  localparam int tb_aw  = 6;
  localparam int seq_dw = 3;
  localparam int n_cb   = 16;
  localparam int n_copy = 8;

  // cycles of each phase counting strobes, drain and read back
  localparam int reset_len   = 9;
  localparam int load_len    = n_cb + 1;
  localparam int copy_len    = 2 * n_copy + 5;
  localparam int new_len     = n_copy + 5;
  localparam int fill_len    = 2 * seq_max + 14;
  localparam int pipe_len    = 2 * n_copy + 9;
  localparam int run_len     = reset_len + load_len + 2 * copy_len + 2 * new_len
                               + 2 * fill_len + pipe_len;
  localparam int cycle_limit = 2 * run_len;

  typedef logic signed [lanes-1:0][rsa_dw-1:0] row_t;

  logic                     clk;
  logic                     sys_rst;
  logic                     cb_we;
  logic [cb_aw-1:0]         cb_waddr;
  row_t                     cb_wdata;
  logic                     cmd_valid;
  tb_op_e                   cmd_op;
  logic [cb_aw-1:0]         cmd_cb_addr;
  logic [tb_aw-1:0]         cmd_tb_addr;
  logic                     lk0;
  logic signed [rsa_dw-1:0] fxi_13;
  logic signed [rsa_dw-1:0] fxi_23;
  logic                     tb_re;
  logic [tb_aw-1:0]         tb_raddr;
  row_t                     tb_rdata;
  logic                     busy;
  int                       phase;
  logic                     report;
  int                       chk_cnt;
  int                       err_cnt;
  logic [15:0]              lfsr_state;
  int                       cycle_cnt;

  tb_write_top #(.rsa_dw(rsa_dw), .cb_aw(cb_aw), .tb_aw(tb_aw), .seq_dw(seq_dw)) UUT (.*);

  tb_write_mon #(.rsa_dw(rsa_dw), .cb_aw(cb_aw), .tb_aw(tb_aw)) u_mon (.*);

  bind tb_write_ctrl tb_write_chk u_chk (
    .clk(clk), .sys_rst(sys_rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .busy(busy), .tb_we(tb_we)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ======================================================================
  // random source with polynomial x^16 + x^14 + x^13 + x^11 + 1
  // ======================================================================

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_word(output logic signed [rsa_dw-1:0] w);
    w = '0;
    for (int b = 0; b < rsa_dw; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[rsa_dw-2:0], lfsr_state[0]};
    end
  endtask

  task automatic draw_row(output row_t r);
    for (int l = 0; l < lanes; l++) begin
      draw_word(r[l]);
    end
  endtask

  // ======================================================================
  // drivers act on the falling edge
  // ======================================================================

  task automatic clear_strobes();
    cb_we     = 1'b0;
    cmd_valid = 1'b0;
    tb_re     = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_strobes();
    end
  endtask

  task automatic load_cb(input int a, input row_t r);
    @(negedge clk);
    clear_strobes();
    cb_we    = 1'b1;
    cb_waddr = cb_aw'(a);
    cb_wdata = r;
  endtask

  task automatic send_cmd(input tb_op_e op, input int cb_a, input int tb_a, input logic lk);
    @(negedge clk);
    clear_strobes();
    cmd_valid   = 1'b1;
    cmd_op      = op;
    cmd_cb_addr = cb_aw'(cb_a);
    cmd_tb_addr = tb_aw'(tb_a);
    lk0         = lk;
  endtask

  task automatic read_back(input int base, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      clear_strobes();
      tb_re    = 1'b1;
      tb_raddr = tb_aw'(base + i);
    end
    idle_cycles(2);  // last read data is compared one cycle later
  endtask

  task automatic copy_phase(input tb_op_e op, input int cb_base, input int tb_base,
                            input logic lk, input int n);
    for (int i = 0; i < n; i++) begin
      send_cmd(op, cb_base + i, tb_base + i, lk);
    end
    idle_cycles(3);  // each copy lands two cycles after its strobe
    read_back(tb_base, n);
  endtask

  task automatic wait_idle();
    do begin
      idle_cycles(1);
    end while (busy);
  endtask

  function automatic tb_op_e pipe_op(int j);
    if (j == n_copy / 2) begin
      return op_nop;
    end
    case (j % 3)
      0:       return op_copy_pos;
      1:       return op_copy_neg;
      default: return op_copy_new;
    endcase
  endfunction

  initial begin : stimulus
    row_t row;
    int   base;
    lfsr_state  = 16'd28;
    phase       = 0;
    report      = 1'b0;
    sys_rst     = 1'b1;
    cmd_op      = op_nop;
    cmd_cb_addr = '0;
    cmd_tb_addr = '0;
    lk0         = 1'b0;
    cb_waddr    = '0;
    cb_wdata    = '0;
    tb_raddr    = '0;
    fxi_13      = '0;
    fxi_23      = '0;
    clear_strobes();
    repeat (8) @(posedge clk);
    @(negedge clk);
    sys_rst = 1'b0;

    phase = 1;
    for (int i = 0; i < n_cb; i++) begin
      draw_row(row);
      load_cb(i, row);
    end
    idle_cycles(1);

    phase = 2;
    copy_phase(op_copy_pos, 0, 0, 1'b0, n_copy);
    phase = 3;
    copy_phase(op_copy_neg, 8, 8, 1'b0, n_copy);
    phase = 4;
    copy_phase(op_copy_new, 0, 16, 1'b1, n_copy / 2);
    copy_phase(op_copy_new, 4, 20, 1'b0, n_copy / 2);

    phase = 5;
    for (int k = 0; k < 2; k++) begin
      base = 32 + 16 * k;
      send_cmd(op_copy_pos, 5 + k, base + 8, 1'b0);  // known row for the lost copy
      idle_cycles(3);
      draw_word(fxi_13);
      draw_word(fxi_23);
      send_cmd(op_nl_fill, 0, base, 1'b0);
      send_cmd(op_copy_neg, 1, base + 8, 1'b0);
      wait_idle();
      read_back(base, seq_max);
      read_back(base + 8, 1);
    end

    phase = 6;
    send_cmd(op_copy_pos, 15, 28, 1'b0);  // the nop strobe targets this row
    idle_cycles(3);
    for (int j = 0; j < n_copy; j++) begin
      send_cmd(pipe_op(j), 8 + j, 24 + j, j[0]);
    end
    idle_cycles(3);
    read_back(24, n_copy);

    report = 1'b1;
    @(negedge clk);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped by timeout after %0d cycles, %0d errors in %0d checks so far",
             cycle_limit, err_cnt, chk_cnt);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- build.f
rtl/tbw_pkg.sv
rtl/cov_bank.sv
rtl/seq_counter.sv
rtl/tb_dina_map.sv
rtl/temp_bank.sv
rtl/tb_write_ctrl.sv
rtl/tb_write_top.sv
sim/tb_write_chk.sv
sim/tb_write_mon.sv
sim/tb_write_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the TB write path testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim_run.log
obj=obj_dir

verilator --binary --timing --assert -f build.f --top-module tb_write_tb \
  -Mdir "$obj" -o tb_write_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

"./$obj/tb_write_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
  exit 1
fi
exit 0
